// ==== design/lane_collector.sv ====
// Output stage. Holds the edited beat until the sink takes it.
// tx_vld marks lanes whose packet survived; dropped lanes read as zero.
`timescale 1ns/1ns
`default_nettype none

module lane_collector #(
    parameter int REGIONS = 4
) (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire                                         advance,
    input  wire [REGIONS-1:0]                           lane_vld,
    input  wire pkt_edit_pkg::lane_pkt_t [REGIONS-1:0]  lane_pkt,
    input  wire pkt_edit_pkg::usermeta_t [REGIONS-1:0]  lane_meta,
    input  wire                                         tx_dst_rdy,
    output logic                                        out_full,
    output pkt_edit_pkg::lane_pkt_t [REGIONS-1:0]       tx_pkt,
    output pkt_edit_pkg::usermeta_t [REGIONS-1:0]       tx_meta,
    output logic [REGIONS-1:0]                          tx_vld,
    output logic                                        tx_src_rdy
);

    // Blocked while a held beat is refused
    assign out_full = tx_src_rdy & ~tx_dst_rdy;

    always_comb begin
        for (int r = 0; r < REGIONS; r++) begin
            tx_vld[r] = tx_src_rdy & tx_pkt[r].present;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tx_src_rdy <= 1'b0;
        end else if (advance) begin
            tx_src_rdy <= |lane_vld;  // All lanes share one beat valid
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            tx_pkt  <= lane_pkt;
            tx_meta <= lane_meta;
        end
    end

    a_tx_hold : assert property (@(posedge clk) disable iff (!rst_n)
        tx_src_rdy && !tx_dst_rdy |=> tx_src_rdy && $stable(tx_pkt)
            && $stable(tx_meta) && $stable(tx_vld));

endmodule

`default_nettype wire

// ==== design/lane_distributor.sv ====
// First pipeline stage. Captures an accepted beat and splits it into lanes.
// Items at or above a packet's length are zeroed here, later stages rely on it.
`timescale 1ns/1ns
`default_nettype none

module lane_distributor #(
    parameter int REGIONS = 4
) (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire pkt_edit_pkg::lane_pkt_t [REGIONS-1:0]  rx_pkt,
    input  wire pkt_edit_pkg::edit_cmd_t [REGIONS-1:0]  rx_cmd,
    input  wire                                         rx_src_rdy,
    input  wire                                         out_full,
    output logic                                        rx_dst_rdy,
    output logic                                        advance,
    output pkt_edit_pkg::lane_pkt_t [REGIONS-1:0]       lane_pkt,
    output pkt_edit_pkg::edit_cmd_t [REGIONS-1:0]       lane_cmd,
    output logic [REGIONS-1:0]                          lane_vld
);

    pkt_edit_pkg::lane_pkt_t [REGIONS-1:0] masked_pkt;

    // Whole pipeline moves only when the output stage can take a beat
    assign advance    = ~out_full;
    assign rx_dst_rdy = advance;

    always_comb begin
        masked_pkt = rx_pkt;
        for (int r = 0; r < REGIONS; r++) begin
            for (int i = 0; i < pkt_edit_pkg::REGION_ITEMS; i++) begin
                if (i >= int'(rx_pkt[r].len)) begin
                    masked_pkt[r].items[i] = '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lane_vld <= '0;
        end else if (advance) begin
            lane_vld <= {REGIONS{rx_src_rdy}};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            lane_pkt <= masked_pkt;
            lane_cmd <= rx_cmd;
        end
    end

    for (genvar r = 0; r < REGIONS; r++) begin : g_len_chk
        // Source must never send more items than a lane holds
        a_len_in_range : assert property (@(posedge clk) disable iff (!rst_n)
            rx_src_rdy && rx_dst_rdy |-> rx_pkt[r].len <= pkt_edit_pkg::REGION_ITEMS);
    end

endmodule

`default_nettype wire

// ==== design/pkt_edit_pkg.sv ====
// Widths and lane types shared by the packet editor.
// One lane carries one short packet of up to REGION_ITEMS items, never spanning lanes.
`default_nettype none

package pkt_edit_pkg;

    localparam int ITEM_W       = 8;
    localparam int REGION_ITEMS = 8;
    localparam int LEN_W        = 4;   // Counts 0..REGION_ITEMS
    localparam int MOD_W        = 3;
    localparam int USERMETA_W   = 16;

    typedef logic [USERMETA_W-1:0] usermeta_t;

    // Item 0 is the first item of the packet
    typedef struct packed {
        logic [REGION_ITEMS-1:0][ITEM_W-1:0] items;
        logic [LEN_W-1:0]                    len;
        logic                                present;
    } lane_pkt_t;

    typedef struct packed {
        usermeta_t        usermeta;
        logic             discard;
        logic             sof_en;
        logic [MOD_W-1:0] sof_trim;  // Items cut from the start
        logic             eof_en;
        logic [MOD_W-1:0] eof_trim;  // Items cut from the end
    } edit_cmd_t;

endpackage

`default_nettype wire

// ==== design/pkt_edit_top.sv ====
// Multi-lane packet editor, three register stages from rx to tx.
// One packet per lane per beat; empty lanes are not compacted.
`timescale 1ns/1ns
`default_nettype none

module pkt_edit_top #(
    parameter int REGIONS = 4   // 1 to 8
) (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire pkt_edit_pkg::lane_pkt_t [REGIONS-1:0]  rx_pkt,
    input  wire pkt_edit_pkg::edit_cmd_t [REGIONS-1:0]  rx_cmd,
    input  wire                                         rx_src_rdy,
    output logic                                        rx_dst_rdy,
    output pkt_edit_pkg::lane_pkt_t [REGIONS-1:0]       tx_pkt,
    output pkt_edit_pkg::usermeta_t [REGIONS-1:0]       tx_meta,
    output logic [REGIONS-1:0]                          tx_vld,
    output logic                                        tx_src_rdy,
    input  wire                                         tx_dst_rdy
);

    logic                                  advance;
    logic                                  out_full;
    pkt_edit_pkg::lane_pkt_t [REGIONS-1:0] lane_pkt;
    pkt_edit_pkg::edit_cmd_t [REGIONS-1:0] lane_cmd;
    logic [REGIONS-1:0]                    lane_vld;
    pkt_edit_pkg::lane_pkt_t [REGIONS-1:0] ed_pkt;
    pkt_edit_pkg::usermeta_t [REGIONS-1:0] ed_meta;
    logic [REGIONS-1:0]                    ed_vld;

    lane_distributor #(
        .REGIONS    (REGIONS)
    ) distributor_u (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_pkt     (rx_pkt),
        .rx_cmd     (rx_cmd),
        .rx_src_rdy (rx_src_rdy),
        .out_full   (out_full),
        .rx_dst_rdy (rx_dst_rdy),
        .advance    (advance),
        .lane_pkt   (lane_pkt),
        .lane_cmd   (lane_cmd),
        .lane_vld   (lane_vld)
    );

    for (genvar r = 0; r < REGIONS; r++) begin : g_editor
        region_editor #(
            .meta_t   (pkt_edit_pkg::usermeta_t)
        ) editor_u (
            .clk      (clk),
            .rst_n    (rst_n),
            .advance  (advance),
            .in_vld   (lane_vld[r]),
            .in_pkt   (lane_pkt[r]),
            .in_cmd   (lane_cmd[r]),
            .out_vld  (ed_vld[r]),
            .out_pkt  (ed_pkt[r]),
            .out_meta (ed_meta[r])
        );
    end

    lane_collector #(
        .REGIONS    (REGIONS)
    ) collector_u (
        .clk        (clk),
        .rst_n      (rst_n),
        .advance    (advance),
        .lane_vld   (ed_vld),
        .lane_pkt   (ed_pkt),
        .lane_meta  (ed_meta),
        .tx_dst_rdy (tx_dst_rdy),
        .out_full   (out_full),
        .tx_pkt     (tx_pkt),
        .tx_meta    (tx_meta),
        .tx_vld     (tx_vld),
        .tx_src_rdy (tx_src_rdy)
    );

endmodule

`default_nettype wire

// ==== design/region_editor.sv ====
// Second pipeline stage for one lane. Applies discard and SOF/EOF trims.
// meta_t must have the width of the command's usermeta field.
// Input items above the length are expected to be zero.
`timescale 1ns/1ns
`default_nettype none

module region_editor #(
    parameter type meta_t = pkt_edit_pkg::usermeta_t
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          advance,
    input  wire                          in_vld,
    input  wire pkt_edit_pkg::lane_pkt_t in_pkt,
    input  wire pkt_edit_pkg::edit_cmd_t in_cmd,
    output logic                         out_vld,
    output pkt_edit_pkg::lane_pkt_t      out_pkt,
    output meta_t                        out_meta
);

    logic [pkt_edit_pkg::MOD_W-1:0]                               sof_cut;
    logic [pkt_edit_pkg::MOD_W-1:0]                               eof_cut;
    logic [pkt_edit_pkg::LEN_W:0]                                 trim_sum;  // Up to 14
    logic                                                         keep;
    logic [pkt_edit_pkg::LEN_W-1:0]                               new_len;
    logic [pkt_edit_pkg::REGION_ITEMS-1:0][pkt_edit_pkg::ITEM_W-1:0] shifted;
    pkt_edit_pkg::lane_pkt_t                                      edited;

    always_comb begin
        sof_cut  = in_cmd.sof_en ? in_cmd.sof_trim : '0;
        eof_cut  = in_cmd.eof_en ? in_cmd.eof_trim : '0;
        trim_sum = (pkt_edit_pkg::LEN_W + 1)'(sof_cut) + (pkt_edit_pkg::LEN_W + 1)'(eof_cut);

        // Dropped if discarded, empty, or trimmed away entirely
        keep = in_pkt.present && !in_cmd.discard && (trim_sum < {1'b0, in_pkt.len});

        new_len = in_pkt.len - trim_sum[pkt_edit_pkg::LEN_W-1:0];

        // Item s moves to index 0
        shifted = in_pkt.items >> (pkt_edit_pkg::ITEM_W * sof_cut);
        for (int i = 0; i < pkt_edit_pkg::REGION_ITEMS; i++) begin
            if (i >= int'(new_len)) begin
                shifted[i] = '0;  // EOF trim cuts the tail
            end
        end

        edited = '0;
        if (keep) begin
            edited.items   = shifted;
            edited.len     = new_len;
            edited.present = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_vld <= 1'b0;
        end else if (advance) begin
            out_vld <= in_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_pkt  <= edited;
            out_meta <= meta_t'(in_cmd.usermeta);  // Passed through untouched
        end
    end

    a_len_shrinks : assert property (@(posedge clk) disable iff (!rst_n)
        advance && in_vld |=> out_pkt.len <= $past(in_pkt.len));

endmodule

`default_nettype wire

// ==== project.f ====
design/pkt_edit_pkg.sv
design/lane_distributor.sv
design/region_editor.sv
design/lane_collector.sv
design/pkt_edit_top.sv
tests/pkt_edit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the packet editor testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module pkt_edit_tb -f project.f -o pkt_edit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/pkt_edit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== tests/pkt_edit_tb.sv ====
// Testbench for pkt_edit_top with four lanes.
// Stimulus and tx_dst_rdy come from one LFSR; a model queue holds the expected beats.
// Outputs are sampled on the falling edge, where they are stable.
`timescale 1ns/1ns
`default_nettype none

module pkt_edit_tb;

    localparam int REGIONS        = 4;
    localparam int RESET_CYCLES   = 10;
    localparam int N_PASS         = 24;
    localparam int N_TRIM         = 40;
    localparam int N_DISC         = 24;
    localparam int N_OVER         = 24;
    localparam int N_BP           = 120;
    localparam int TIMEOUT_CYCLES =
        2 * (RESET_CYCLES + N_PASS + N_TRIM + N_DISC + N_OVER + N_BP) + 50;
    localparam logic [31:0] LFSR_SEED = 32'h2ea59626;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    typedef struct packed {
        pkt_edit_pkg::lane_pkt_t [REGIONS-1:0] pkt;
        pkt_edit_pkg::usermeta_t [REGIONS-1:0] meta;
        logic [REGIONS-1:0]                    vld;
        logic [31:0]                           acc_cyc;  // Cycle of acceptance
    } beat_t;

    logic                                  clk;
    logic                                  rst_n;
    pkt_edit_pkg::lane_pkt_t [REGIONS-1:0] rx_pkt;
    pkt_edit_pkg::edit_cmd_t [REGIONS-1:0] rx_cmd;
    logic                                  rx_src_rdy;
    logic                                  rx_dst_rdy;
    pkt_edit_pkg::lane_pkt_t [REGIONS-1:0] tx_pkt;
    pkt_edit_pkg::usermeta_t [REGIONS-1:0] tx_meta;
    logic [REGIONS-1:0]                    tx_vld;
    logic                                  tx_src_rdy;
    logic                                  tx_dst_rdy;

    beat_t                                 exp_q[$];
    logic [31:0]                           lfsr;
    int                                    cycle = 0;
    int                                    errors = 0;
    int                                    beats_checked = 0;
    logic                                  held = 1'b0;
    logic                                  lat_checked = 1'b0;
    pkt_edit_pkg::lane_pkt_t [REGIONS-1:0] held_pkt;
    pkt_edit_pkg::usermeta_t [REGIONS-1:0] held_meta;
    logic [REGIONS-1:0]                    held_vld;

    pkt_edit_top #(
        .REGIONS    (REGIONS)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_pkt     (rx_pkt),
        .rx_cmd     (rx_cmd),
        .rx_src_rdy (rx_src_rdy),
        .rx_dst_rdy (rx_dst_rdy),
        .tx_pkt     (tx_pkt),
        .tx_meta    (tx_meta),
        .tx_vld     (tx_vld),
        .tx_src_rdy (tx_src_rdy),
        .tx_dst_rdy (tx_dst_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Galois LFSR, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input logic [511:0] exp_val,
                                   input logic [511:0] got_val);
        errors++;
        $display("Error: time %0t %s expected %0h got %0h", $time, name, exp_val, got_val);
    endtask

    // Keep items s .. len-e-1, moved down to index 0
    function automatic pkt_edit_pkg::lane_pkt_t expect_lane(input pkt_edit_pkg::lane_pkt_t p,
                                                            input pkt_edit_pkg::edit_cmd_t c);
        pkt_edit_pkg::lane_pkt_t q;
        int s;
        int e;
        int left;
        q    = '0;
        s    = c.sof_en ? int'(c.sof_trim) : 0;
        e    = c.eof_en ? int'(c.eof_trim) : 0;
        left = int'(p.len) - s - e;
        if (p.present && !c.discard && left > 0) begin
            q.present = 1'b1;
            q.len     = 4'(left);
            for (int i = 0; i < left; i++) begin
                q.items[i] = p.items[i + s];
            end
        end
        return q;
    endfunction

    task automatic drive_beat(input int mode);
        pkt_edit_pkg::lane_pkt_t p;
        pkt_edit_pkg::edit_cmd_t c;
        for (int r = 0; r < REGIONS; r++) begin
            p = '0;
            c = '0;
            for (int i = 0; i < pkt_edit_pkg::REGION_ITEMS; i++) begin
                p.items[i] = 8'(take_bits(8));  // Junk above len on purpose
            end
            p.len      = 4'(take_bits(4) % 9);
            p.present  = (take_bits(3) != 0);
            c.usermeta = 16'(take_bits(16));
            if (mode == 1 || mode == 4) begin
                c.sof_en   = 1'(take_bits(1));
                c.sof_trim = 3'(take_bits(3));
                c.eof_en   = 1'(take_bits(1));
                c.eof_trim = 3'(take_bits(3));
            end
            if (mode == 2) c.discard = 1'(take_bits(1));
            if (mode == 4) c.discard = (take_bits(3) == 0);
            if (mode == 3) begin
                p.len      = 4'(take_bits(3));  // Short packets, trims often reach len
                c.sof_en   = 1'b1;
                c.eof_en   = 1'b1;
                c.sof_trim = 3'(take_bits(3));
                c.eof_trim = 3'(take_bits(3));
            end
            rx_pkt[r] = p;
            rx_cmd[r] = c;
        end
    endtask

    // Sends n beats; with bp set, adds idle gaps and random tx_dst_rdy
    task automatic run_beats(input int n, input int mode, input logic bp);
        int   sent;
        logic acc;
        sent = 0;
        while (sent < n) begin
            @(negedge clk);
            acc = rx_src_rdy && rx_dst_rdy;
            @(posedge clk);
            #1;
            if (acc) sent++;
            if (acc || !rx_src_rdy) begin
                if (sent < n && !(bp && take_bits(2) == 0)) begin
                    rx_src_rdy = 1'b1;
                    drive_beat(mode);
                end else begin
                    rx_src_rdy = 1'b0;
                end
            end
            tx_dst_rdy = bp ? (take_bits(2) != 0) : 1'b1;
        end
    endtask

    always @(negedge clk) begin
        beat_t b;
        beat_t e;
        if (rst_n) begin
            // Ready when the sink takes the held beat or nothing is held
            a_rdy : assert (rx_dst_rdy == (tx_dst_rdy || !tx_src_rdy)) else
                report_mismatch("rx_dst_rdy", 512'(tx_dst_rdy || !tx_src_rdy),
                                512'(rx_dst_rdy));
            if (!tx_src_rdy) begin
                a_vld_idle : assert (tx_vld == '0) else
                    report_mismatch("tx_vld", 512'(0), 512'(tx_vld));
            end
            if (held) begin
                a_hold_src : assert (tx_src_rdy) else
                    report_mismatch("tx_src_rdy", 512'(1), 512'(tx_src_rdy));
                a_hold_pkt : assert (tx_pkt == held_pkt) else
                    report_mismatch("tx_pkt", 512'(held_pkt), 512'(tx_pkt));
                a_hold_meta : assert (tx_meta == held_meta) else
                    report_mismatch("tx_meta", 512'(held_meta), 512'(tx_meta));
                a_hold_vld : assert (tx_vld == held_vld) else
                    report_mismatch("tx_vld", 512'(held_vld), 512'(tx_vld));
            end
            held      = tx_src_rdy && !tx_dst_rdy;
            held_pkt  = tx_pkt;
            held_meta = tx_meta;
            held_vld  = tx_vld;
            if (tx_src_rdy && tx_dst_rdy) begin
                a_expected : assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("Error: time %0t an output beat arrived with none expected", $time);
                end
                if (exp_q.size() != 0) begin
                    e = exp_q.pop_front();
                    beats_checked++;
                    if (!lat_checked) begin
                        lat_checked = 1'b1;
                        a_latency : assert (cycle - int'(e.acc_cyc) == 3) else
                            report_mismatch("latency", 512'(3), 512'(cycle - int'(e.acc_cyc)));
                    end
                    for (int r = 0; r < REGIONS; r++) begin
                        a_items : assert (tx_pkt[r].items == e.pkt[r].items) else
                            report_mismatch($sformatf("tx_pkt[%0d].items", r),
                                            512'(e.pkt[r].items), 512'(tx_pkt[r].items));
                        a_len : assert (tx_pkt[r].len == e.pkt[r].len) else
                            report_mismatch($sformatf("tx_pkt[%0d].len", r),
                                            512'(e.pkt[r].len), 512'(tx_pkt[r].len));
                        a_present : assert (tx_pkt[r].present == e.pkt[r].present) else
                            report_mismatch($sformatf("tx_pkt[%0d].present", r),
                                            512'(e.pkt[r].present), 512'(tx_pkt[r].present));
                        a_meta : assert (tx_meta[r] == e.meta[r]) else
                            report_mismatch($sformatf("tx_meta[%0d]", r),
                                            512'(e.meta[r]), 512'(tx_meta[r]));
                        a_vld : assert (tx_vld[r] == e.vld[r]) else
                            report_mismatch($sformatf("tx_vld[%0d]", r),
                                            512'(e.vld[r]), 512'(tx_vld[r]));
                    end
                end
            end
            if (rx_src_rdy && rx_dst_rdy) begin
                b = '0;
                for (int r = 0; r < REGIONS; r++) begin
                    b.pkt[r]  = expect_lane(rx_pkt[r], rx_cmd[r]);
                    b.meta[r] = rx_cmd[r].usermeta;
                    b.vld[r]  = b.pkt[r].present;
                end
                b.acc_cyc = cycle;
                exp_q.push_back(b);
            end
        end
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Summary: %0d beats checked, %0d errors", beats_checked, errors);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        rst_n      = 1'b0;
        rx_pkt     = '0;
        rx_cmd     = '0;
        rx_src_rdy = 1'b0;
        tx_dst_rdy = 1'b1;
        lfsr       = LFSR_SEED;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        a_rst_src : assert (tx_src_rdy == 1'b0) else
            report_mismatch("tx_src_rdy", 512'(0), 512'(tx_src_rdy));
        a_rst_vld : assert (tx_vld == '0) else
            report_mismatch("tx_vld", 512'(0), 512'(tx_vld));
        a_rst_dst : assert (rx_dst_rdy == 1'b1) else
            report_mismatch("rx_dst_rdy", 512'(1), 512'(rx_dst_rdy));
        run_beats(N_PASS, 0, 1'b0);
        run_beats(N_TRIM, 1, 1'b0);
        run_beats(N_DISC, 2, 1'b0);
        run_beats(N_OVER, 3, 1'b0);
        run_beats(N_BP, 4, 1'b1);
        tx_dst_rdy = 1'b1;
        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);  // Room for any stray beat to show up
        $display("Summary: %0d beats checked, %0d errors", beats_checked, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
